//--- compile.f
+incdir+logic
logic/rvfi_pkg.sv
logic/core_sequencer.sv
logic/regfile.sv
logic/exec_unit.sv
logic/unified_memory.sv
logic/rvfi_tracker.sv
logic/rvfi_core_top.sv
testbench/rvfi_core_checker.sv
testbench/rvfi_core_tb.sv

//--- Makefile
# Verilator build and run for the RVFI core testbench

VERILATOR ?= verilator
TOP       ?= rvfi_core_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/rvfi_core_patterns.txt
# P word_addr word : preload one memory word (word address, hex)
# R pc insn rd_addr rd_wdata mem_addr wmask trap : expected record, in retire order
P 000 00500093
P 001 00C00113
P 002 002081B3
P 003 40110233
P 004 0020F2B3
P 005 0020E333
P 006 0020C3B3
P 007 12345437
P 008 00108013
P 009 10302023
P 00A 10002483
P 00B 00208463
P 00C 00209463
P 00D 00100513
P 00E 00348463
P 00F 00100513
P 010 008005EF
P 011 00100513
P 012 00109463
P 013 00000000
P 040 DEADBEEF
R 00000000 00500093 01 00000005 00000000 0 0
R 00000004 00C00113 02 0000000C 00000000 0 0
R 00000008 002081B3 03 00000011 00000000 0 0
R 0000000C 40110233 04 00000007 00000000 0 0
R 00000010 0020F2B3 05 00000004 00000000 0 0
R 00000014 0020E333 06 0000000D 00000000 0 0
R 00000018 0020C3B3 07 00000009 00000000 0 0
R 0000001C 12345437 08 12345000 00000000 0 0
R 00000020 00108013 00 00000000 00000000 0 0
R 00000024 10302023 00 00000000 00000100 F 0
R 00000028 10002483 09 00000011 00000100 0 0
R 0000002C 00208463 00 00000000 00000000 0 0
R 00000030 00209463 00 00000000 00000000 0 0
R 00000038 00348463 00 00000000 00000000 0 0
R 00000040 008005EF 0B 00000044 00000000 0 0
R 00000048 00109463 00 00000000 00000000 0 0
R 0000004C 00000000 00 00000000 00000000 0 1

//--- testbench/rvfi_core_tb.sv
/*
 * Testbench for the RVFI core
 * Preloads a program from the pattern file, runs the core and
 * compares every retirement record with the expected one
 */

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_core_tb;

  localparam int WAIT_LIMIT = 200;

  logic                    clock;
  logic                    reset;
  logic                    run;
  logic                    load_valid;
  logic [`RVFI_MEM_AW-1:0] load_addr;
  logic [31:0]             load_data;
  logic                    rvfi_valid;
  logic [63:0]             rvfi_order;
  logic [31:0]             rvfi_insn;
  logic                    rvfi_trap;
  logic                    rvfi_halt;
  logic                    rvfi_intr;
  logic [1:0]              rvfi_mode;
  logic [1:0]              rvfi_ixl;
  logic [4:0]              rvfi_rs1_addr;
  logic [4:0]              rvfi_rs2_addr;
  logic [31:0]             rvfi_rs1_rdata;
  logic [31:0]             rvfi_rs2_rdata;
  logic [4:0]              rvfi_rd_addr;
  logic [31:0]             rvfi_rd_wdata;
  logic [31:0]             rvfi_pc_rdata;
  logic [31:0]             rvfi_pc_wdata;
  logic [31:0]             rvfi_mem_addr;
  logic [3:0]              rvfi_mem_rmask;
  logic [3:0]              rvfi_mem_wmask;
  logic [31:0]             rvfi_mem_rdata;
  logic [31:0]             rvfi_mem_wdata;

  // Parsed pattern file
  logic [31:0] pre_addr [$];
  logic [31:0] pre_word [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_insn [$];
  logic [31:0] exp_rd_addr [$];
  logic [31:0] exp_rd_wdata [$];
  logic [31:0] exp_mem_addr [$];
  logic [31:0] exp_wmask [$];
  logic [31:0] exp_trap [$];

  // Register values as the expected records leave them
  logic [31:0] shadow [32];
  int          errors;
  int          timeouts;
  int          checked;
  logic        aborted;

  rvfi_core_top i_dut (.*);

  always #4 clock = ~clock;

  // ==================================================
  // Pattern file and preload
  // ==================================================
  task automatic read_patterns();
    int          fd;
    string       line;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_c;
    logic [31:0] f_d;
    logic [31:0] f_e;
    logic [31:0] f_f;
    logic [31:0] f_g;
    fd = $fopen("testbench/rvfi_core_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the pattern file testbench/rvfi_core_patterns.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "P %h %h", f_a, f_b) == 2) begin
        pre_addr.push_back(f_a);
        pre_word.push_back(f_b);
      end else if ($sscanf(line, "R %h %h %h %h %h %h %h",
                           f_a, f_b, f_c, f_d, f_e, f_f, f_g) == 7) begin
        exp_pc.push_back(f_a);
        exp_insn.push_back(f_b);
        exp_rd_addr.push_back(f_c);
        exp_rd_wdata.push_back(f_d);
        exp_mem_addr.push_back(f_e);
        exp_wmask.push_back(f_f);
        exp_trap.push_back(f_g);
      end
    end
    $fclose(fd);
  endtask

  // One word per cycle while run is low
  task automatic preload_memory();
    for (int i = 0; i < pre_addr.size(); i++) begin
      @(posedge clock);
      #1;
      load_valid = 1'b1;
      load_addr  = pre_addr[i][`RVFI_MEM_AW-1:0];
      load_data  = pre_word[i];
    end
    @(posedge clock);
    #1;
    load_valid = 1'b0;
  endtask

  // ==================================================
  // Retirement wait and record compare
  // ==================================================
  // Sampled on the falling edge, mid-cycle of the pulse
  task automatic wait_retire(output logic seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && (cycles < WAIT_LIMIT)) begin
      @(negedge clock);
      if (rvfi_valid === 1'b1) seen = 1'b1;
      cycles++;
    end
  endtask

  function automatic void compare_value(string name, logic [31:0] actual,
                                        logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
    end
  endfunction

  task automatic check_record(int idx);
    logic [31:0] insn_w;
    logic [31:0] next_pc;
    logic [31:0] rmask;
    logic [31:0] store_val;
    logic [31:0] load_val;
    logic [6:0]  opc;
    logic [4:0]  rs1_exp;
    logic [4:0]  rs2_exp;
    insn_w  = exp_insn[idx];
    opc     = insn_w[6:0];
    // Trap keeps the PC, otherwise the next record's PC
    next_pc = (exp_trap[idx] != 32'd0) ? exp_pc[idx] : exp_pc[idx + 1];
    // LW opcode reads a full word
    rmask     = (opc == 7'b0000011) ? 32'hF : 32'h0;
    store_val = (exp_wmask[idx] != 32'd0) ? shadow[insn_w[24:20]] : 32'h0;
    load_val  = (rmask != 32'd0) ? exp_rd_wdata[idx] : 32'h0;
    // LUI, JAL and traps name no source register
    if ((opc == 7'b0110111) || (opc == 7'b1101111) || (exp_trap[idx] != 32'd0)) begin
      rs1_exp = 5'd0;
    end else begin
      rs1_exp = insn_w[19:15];
    end
    // Register-register, store and branch formats read rs2
    if ((opc == 7'b0110011) || (opc == 7'b0100011) || (opc == 7'b1100011)) begin
      rs2_exp = insn_w[24:20];
    end else begin
      rs2_exp = 5'd0;
    end
    if (rvfi_order !== 64'(idx)) begin
      errors++;
      $display("[FAIL] rvfi_order: got %h, expected %h", rvfi_order, 64'(idx));
    end
    compare_value("rvfi_insn", rvfi_insn, insn_w);
    compare_value("rvfi_pc_rdata", rvfi_pc_rdata, exp_pc[idx]);
    compare_value("rvfi_pc_wdata", rvfi_pc_wdata, next_pc);
    compare_value("rvfi_rd_addr", {27'h0, rvfi_rd_addr}, exp_rd_addr[idx]);
    compare_value("rvfi_rd_wdata", rvfi_rd_wdata, exp_rd_wdata[idx]);
    // Source operands against earlier writes
    compare_value("rvfi_rs1_addr", {27'h0, rvfi_rs1_addr}, {27'h0, rs1_exp});
    compare_value("rvfi_rs2_addr", {27'h0, rvfi_rs2_addr}, {27'h0, rs2_exp});
    compare_value("rvfi_rs1_rdata", rvfi_rs1_rdata, shadow[rs1_exp]);
    compare_value("rvfi_rs2_rdata", rvfi_rs2_rdata, shadow[rs2_exp]);
    compare_value("rvfi_mem_addr", rvfi_mem_addr, exp_mem_addr[idx]);
    compare_value("rvfi_mem_wmask", {28'h0, rvfi_mem_wmask}, exp_wmask[idx]);
    compare_value("rvfi_mem_rmask", {28'h0, rvfi_mem_rmask}, rmask);
    compare_value("rvfi_mem_wdata", rvfi_mem_wdata, store_val);
    compare_value("rvfi_mem_rdata", rvfi_mem_rdata, load_val);
    compare_value("rvfi_trap", {31'h0, rvfi_trap}, exp_trap[idx]);
    compare_value("rvfi_halt", {31'h0, rvfi_halt}, exp_trap[idx]);
    // Fixed fields, M-mode RV32 without interrupts
    compare_value("rvfi_intr", {31'h0, rvfi_intr}, 32'h0);
    compare_value("rvfi_mode", {30'h0, rvfi_mode}, 32'h3);
    compare_value("rvfi_ixl", {30'h0, rvfi_ixl}, 32'h1);
    if (exp_rd_addr[idx] != 32'd0) shadow[exp_rd_addr[idx][4:0]] = exp_rd_wdata[idx];
    checked++;
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    logic seen;
    int   assert_total;
    clock      = 1'b0;
    reset      = 1'b1;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = 32'h0;
    errors     = 0;
    timeouts   = 0;
    checked    = 0;
    aborted    = 1'b0;
    for (int r = 0; r < 32; r++) shadow[r] = 32'h0;
    read_patterns();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    preload_memory();
    @(posedge clock);
    #1;
    run = 1'b1;
    for (int i = 0; (i < exp_pc.size()) && !aborted; i++) begin
      wait_retire(seen);
      if (!seen) begin
        timeouts++;
        aborted = 1'b1;
        $display("Timeout: record %0d did not retire within %0d cycles", i, WAIT_LIMIT);
      end else begin
        check_record(i);
      end
    end
    // Halt record must be the last one
    if (!aborted) begin
      wait_retire(seen);
      if (seen) begin
        errors++;
        $display("A retirement was reported after the halt record");
      end
    end
    assert_total = i_dut.i_checker.pulse_errors + i_dut.i_checker.order_errors +
                   i_dut.i_checker.halt_errors;
    $display("Summary: %0d of %0d records checked, %0d errors, %0d timeouts, %0d assertion errors",
             checked, exp_pc.size(), errors, timeouts, assert_total);
    if ((errors == 0) && (timeouts == 0) && (assert_total == 0) &&
        (checked == exp_pc.size()) && (checked > 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- testbench/rvfi_core_checker.sv
/*
 * RVFI protocol checker, bound into the core top level
 * Single-cycle valid, gapless order, nothing after halt
 */

`timescale 1ns/1ps

module rvfi_core_checker (
  input  logic        clock,
  input  logic        reset,
  input  logic        rvfi_valid,
  input  logic [63:0] rvfi_order,
  input  logic        rvfi_halt
);

  logic [63:0] last_order;
  logic        seen_pulse;
  logic        halt_seen;
  // Failure counts, read by the testbench at the end
  int pulse_errors = 0;
  int order_errors = 0;
  int halt_errors  = 0;

  // Order of the previous pulse and sticky halt flag
  always_ff @(posedge clock) begin
    if (reset) begin
      last_order <= 64'd0;
      seen_pulse <= 1'b0;
      halt_seen  <= 1'b0;
    end else if (rvfi_valid) begin
      last_order <= rvfi_order;
      seen_pulse <= 1'b1;
      if (rvfi_halt) halt_seen <= 1'b1;
    end
  end

  // ==================================================
  // Protocol rules
  // ==================================================
  single_pulse: assert property (@(posedge clock) disable iff (reset)
    rvfi_valid |=> !rvfi_valid)
    else begin
      pulse_errors++;
      $error("rvfi_valid held for more than one cycle");
    end

  // First retirement is order 0, then +1 per pulse
  order_step: assert property (@(posedge clock) disable iff (reset)
    rvfi_valid |-> (rvfi_order == (seen_pulse ? last_order + 64'd1 : 64'd0)))
    else begin
      order_errors++;
      $error("rvfi_order did not step by one");
    end

  no_pulse_after_halt: assert property (@(posedge clock) disable iff (reset)
    halt_seen |-> !rvfi_valid)
    else begin
      halt_errors++;
      $error("rvfi_valid seen after a halt record");
    end

endmodule

bind rvfi_core_top rvfi_core_checker i_checker (
  .clock      (clock),
  .reset      (reset),
  .rvfi_valid (rvfi_valid),
  .rvfi_order (rvfi_order),
  .rvfi_halt  (rvfi_halt)
);

//--- logic/rvfi_core_top.sv
/*
 * RVFI core top level
 * Multi-cycle RV32I subset core with preload port
 * and a full RVFI retirement port
 */

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_core_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    run,
  input  logic                    load_valid,
  input  logic [`RVFI_MEM_AW-1:0] load_addr,
  input  logic [31:0]             load_data,
  output logic                    rvfi_valid,
  output logic [63:0]             rvfi_order,
  output logic [31:0]             rvfi_insn,
  output logic                    rvfi_trap,
  output logic                    rvfi_halt,
  output logic                    rvfi_intr,
  output logic [1:0]              rvfi_mode,
  output logic [1:0]              rvfi_ixl,
  output logic [4:0]              rvfi_rs1_addr,
  output logic [4:0]              rvfi_rs2_addr,
  output logic [31:0]             rvfi_rs1_rdata,
  output logic [31:0]             rvfi_rs2_rdata,
  output logic [4:0]              rvfi_rd_addr,
  output logic [31:0]             rvfi_rd_wdata,
  output logic [31:0]             rvfi_pc_rdata,
  output logic [31:0]             rvfi_pc_wdata,
  output logic [31:0]             rvfi_mem_addr,
  output logic [3:0]              rvfi_mem_rmask,
  output logic [3:0]              rvfi_mem_wmask,
  output logic [31:0]             rvfi_mem_rdata,
  output logic [31:0]             rvfi_mem_wdata
);

  // ==================================================
  // Internal wires
  // ==================================================
  logic          fetch_en;
  logic          mem_en;
  logic          retire_en;
  logic          halted;
  logic          store_en;
  rvfi_pkg::op_e op;
  logic [31:0]   pc;
  logic [31:0]   insn;
  logic [31:0]   rdata;
  logic [31:0]   rs1_rdata;
  logic [31:0]   rs2_rdata;
  logic [4:0]    rd_addr;
  logic [31:0]   rd_wdata;
  logic          rd_write;
  logic [31:0]   next_pc;
  logic [31:0]   mem_addr;
  logic [31:0]   store_data;

  // Memory step writes only for stores
  assign store_en = (op == rvfi_pkg::OP_SW);

  // ==================================================
  // Control
  // ==================================================
  core_sequencer i_sequencer (
    .clock     (clock),
    .reset     (reset),
    .run       (run),
    .op        (op),
    .fetch_en  (fetch_en),
    .mem_en    (mem_en),
    .retire_en (retire_en),
    .halted    (halted)
  );

  // ==================================================
  // Datapath
  // ==================================================
  // rd_addr is zero for non-writing ops, so retire_en alone is safe
  regfile i_regfile (
    .clock     (clock),
    .rs1_addr  (insn[19:15]),
    .rs2_addr  (insn[24:20]),
    .rd_addr   (rd_addr),
    .rd_wdata  (rd_wdata),
    .write_en  (retire_en),
    .rs1_rdata (rs1_rdata),
    .rs2_rdata (rs2_rdata)
  );

  exec_unit i_exec (
    .insn       (insn),
    .pc         (pc),
    .rs1_rdata  (rs1_rdata),
    .rs2_rdata  (rs2_rdata),
    .load_data  (rdata),
    .op         (op),
    .rd_addr    (rd_addr),
    .rd_wdata   (rd_wdata),
    .next_pc    (next_pc),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .rd_write   (rd_write)
  );

  // Preload is blocked while the core drives the port
  unified_memory i_memory (
    .clock      (clock),
    .fetch_en   (fetch_en),
    .mem_en     (mem_en),
    .store_en   (store_en),
    .pc         (pc),
    .mem_addr   (mem_addr),
    .store_data (store_data),
    .load_valid (load_valid && (halted || !run)),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .rdata      (rdata)
  );

  // ==================================================
  // Retirement tracking
  // ==================================================
  rvfi_tracker i_tracker (
    .clock          (clock),
    .reset          (reset),
    .fetch_en       (fetch_en),
    .retire_en      (retire_en),
    .rdata          (rdata),
    .op             (op),
    .rs1_rdata      (rs1_rdata),
    .rs2_rdata      (rs2_rdata),
    .rd_addr        (rd_addr),
    .rd_wdata       (rd_wdata),
    .rd_write       (rd_write),
    .next_pc        (next_pc),
    .mem_addr       (mem_addr),
    .store_data     (store_data),
    .pc             (pc),
    .insn           (insn),
    .rvfi_valid     (rvfi_valid),
    .rvfi_order     (rvfi_order),
    .rvfi_insn      (rvfi_insn),
    .rvfi_trap      (rvfi_trap),
    .rvfi_halt      (rvfi_halt),
    .rvfi_intr      (rvfi_intr),
    .rvfi_mode      (rvfi_mode),
    .rvfi_ixl       (rvfi_ixl),
    .rvfi_rs1_addr  (rvfi_rs1_addr),
    .rvfi_rs2_addr  (rvfi_rs2_addr),
    .rvfi_rs1_rdata (rvfi_rs1_rdata),
    .rvfi_rs2_rdata (rvfi_rs2_rdata),
    .rvfi_rd_addr   (rvfi_rd_addr),
    .rvfi_rd_wdata  (rvfi_rd_wdata),
    .rvfi_pc_rdata  (rvfi_pc_rdata),
    .rvfi_pc_wdata  (rvfi_pc_wdata),
    .rvfi_mem_addr  (rvfi_mem_addr),
    .rvfi_mem_rmask (rvfi_mem_rmask),
    .rvfi_mem_wmask (rvfi_mem_wmask),
    .rvfi_mem_rdata (rvfi_mem_rdata),
    .rvfi_mem_wdata (rvfi_mem_wdata)
  );

endmodule

//--- logic/rvfi_tracker.sv
/*
 * RVFI tracker
 * Owns PC and instruction registers, builds one retirement
 * record per instruction and numbers the retirements
 */

`timescale 1ns/1ps

`include "rvfi_params.svh"

module rvfi_tracker (
  input  logic           clock,
  input  logic           reset,
  input  logic           fetch_en,
  input  logic           retire_en,
  input  logic [31:0]    rdata,
  input  rvfi_pkg::op_e  op,
  input  logic [31:0]    rs1_rdata,
  input  logic [31:0]    rs2_rdata,
  input  logic [4:0]     rd_addr,
  input  logic [31:0]    rd_wdata,
  input  logic           rd_write,
  input  logic [31:0]    next_pc,
  input  logic [31:0]    mem_addr,
  input  logic [31:0]    store_data,
  output logic [31:0]    pc,
  output logic [31:0]    insn,
  output logic           rvfi_valid,
  output logic [63:0]    rvfi_order,
  output logic [31:0]    rvfi_insn,
  output logic           rvfi_trap,
  output logic           rvfi_halt,
  output logic           rvfi_intr,
  output logic [1:0]     rvfi_mode,
  output logic [1:0]     rvfi_ixl,
  output logic [4:0]     rvfi_rs1_addr,
  output logic [4:0]     rvfi_rs2_addr,
  output logic [31:0]    rvfi_rs1_rdata,
  output logic [31:0]    rvfi_rs2_rdata,
  output logic [4:0]     rvfi_rd_addr,
  output logic [31:0]    rvfi_rd_wdata,
  output logic [31:0]    rvfi_pc_rdata,
  output logic [31:0]    rvfi_pc_wdata,
  output logic [31:0]    rvfi_mem_addr,
  output logic [3:0]     rvfi_mem_rmask,
  output logic [3:0]     rvfi_mem_wmask,
  output logic [31:0]    rvfi_mem_rdata,
  output logic [31:0]    rvfi_mem_wdata
);

  logic        fetch_q;
  logic [31:0] insn_q;
  logic        is_lw;
  logic        is_sw;
  logic        uses_rs1;
  logic        uses_rs2;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;

  // ==================================================
  // PC and instruction
  // ==================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      pc      <= `RVFI_RESET_PC;
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= fetch_en;
      if (retire_en) pc <= next_pc;
    end
  end

  // Capture the word the moment the fetch read returns
  always_ff @(posedge clock) begin
    if (fetch_q) insn_q <= rdata;
  end

  // Straight from memory in the return cycle, held afterwards
  assign insn = fetch_q ? rdata : insn_q;

  // ==================================================
  // Operand usage
  // ==================================================
  assign is_lw    = (op == rvfi_pkg::OP_LW);
  assign is_sw    = (op == rvfi_pkg::OP_SW);
  // Unused sources report as x0
  assign uses_rs1 = !((op == rvfi_pkg::OP_LUI) || (op == rvfi_pkg::OP_JAL) ||
                      (op == rvfi_pkg::OP_ILLEGAL));
  assign uses_rs2 = (op == rvfi_pkg::OP_ADD) || (op == rvfi_pkg::OP_SUB) ||
                    (op == rvfi_pkg::OP_AND) || (op == rvfi_pkg::OP_OR)  ||
                    (op == rvfi_pkg::OP_XOR) || is_sw ||
                    (op == rvfi_pkg::OP_BEQ) || (op == rvfi_pkg::OP_BNE);
  assign rs1_addr = uses_rs1 ? insn[19:15] : 5'd0;
  assign rs2_addr = uses_rs2 ? insn[24:20] : 5'd0;

  // ==================================================
  // Retirement record
  // ==================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      rvfi_valid <= 1'b0;
      rvfi_order <= 64'd0;
    end else begin
      // One cycle pulse per retire
      rvfi_valid <= retire_en;
      if (rvfi_valid) rvfi_order <= rvfi_order + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (retire_en) begin
      rvfi_insn      <= insn;
      rvfi_trap      <= (op == rvfi_pkg::OP_ILLEGAL);
      rvfi_halt      <= (op == rvfi_pkg::OP_ILLEGAL);
      rvfi_rs1_addr  <= rs1_addr;
      rvfi_rs2_addr  <= rs2_addr;
      rvfi_rs1_rdata <= uses_rs1 ? rs1_rdata : 32'h0;
      rvfi_rs2_rdata <= uses_rs2 ? rs2_rdata : 32'h0;
      rvfi_rd_addr   <= rd_addr;
      // x0 destination reports zero data
      rvfi_rd_wdata  <= (rd_write && (rd_addr != 5'd0)) ? rd_wdata : 32'h0;
      rvfi_pc_rdata  <= pc;
      rvfi_pc_wdata  <= next_pc;
      // Word-only accesses, full masks
      rvfi_mem_addr  <= (is_lw || is_sw) ? mem_addr : 32'h0;
      rvfi_mem_rmask <= is_lw ? 4'hF : 4'h0;
      rvfi_mem_wmask <= is_sw ? 4'hF : 4'h0;
      rvfi_mem_rdata <= is_lw ? rdata : 32'h0;
      rvfi_mem_wdata <= is_sw ? store_data : 32'h0;
    end
  end

  // No interrupts, M-mode only, RV32
  assign rvfi_intr = 1'b0;
  assign rvfi_mode = 2'b11;
  assign rvfi_ixl  = 2'b01;

endmodule

//--- logic/unified_memory.sv
/*
 * Unified instruction and data memory
 * Single port, registered read, word addressed
 * Shared by fetch, load/store and the preload strobe
 */

`timescale 1ns/1ps

`include "rvfi_params.svh"

module unified_memory (
  input  logic                    clock,
  input  logic                    fetch_en,
  input  logic                    mem_en,
  input  logic                    store_en,
  input  logic [31:0]             pc,
  input  logic [31:0]             mem_addr,
  input  logic [31:0]             store_data,
  input  logic                    load_valid,
  input  logic [`RVFI_MEM_AW-1:0] load_addr,
  input  logic [31:0]             load_data,
  output logic [31:0]             rdata
);

  logic [31:0] mem [`RVFI_MEM_WORDS];

  // Byte addresses to word index, low two bits dropped
  logic [`RVFI_MEM_AW-1:0] data_word;
  logic [`RVFI_MEM_AW-1:0] read_word;

  assign data_word = mem_addr[`RVFI_MEM_AW+1:2];
  // Fetch owns the port in FETCH, the datapath in MEMORY
  assign read_word = fetch_en ? pc[`RVFI_MEM_AW+1:2] : data_word;

  always_ff @(posedge clock) begin
    // Core store first
    if (mem_en && store_en) begin
      mem[data_word] <= store_data;
    end else if (load_valid && !fetch_en && !mem_en) begin
      // Preload only when the core is not using the port
      mem[load_addr] <= load_data;
    end
    // Read data holds between accesses
    if (fetch_en || (mem_en && !store_en)) begin
      rdata <= mem[read_word];
    end
  end

endmodule

//--- logic/exec_unit.sv
/*
 * Execute unit
 * Decode, immediates, ALU, branch compare and next PC
 * Purely combinational, held stable by the sequencer
 */

`timescale 1ns/1ps

module exec_unit (
  input  logic [31:0]    insn,
  input  logic [31:0]    pc,
  input  logic [31:0]    rs1_rdata,
  input  logic [31:0]    rs2_rdata,
  input  logic [31:0]    load_data,
  output rvfi_pkg::op_e  op,
  output logic [4:0]     rd_addr,
  output logic [31:0]    rd_wdata,
  output logic [31:0]    next_pc,
  output logic [31:0]    mem_addr,
  output logic [31:0]    store_data,
  output logic           rd_write
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] pc_plus4;
  logic        taken;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // ==================================================
  // Decode
  // ==================================================
  always_comb begin
    op = rvfi_pkg::OP_ILLEGAL;
    case (opcode)
      7'b0010011: begin
        if (funct3 == 3'b000) op = rvfi_pkg::OP_ADDI;
      end
      7'b0110011: begin
        // R-type, funct7 picks ADD vs SUB
        case ({funct7, funct3})
          10'b0000000_000: op = rvfi_pkg::OP_ADD;
          10'b0100000_000: op = rvfi_pkg::OP_SUB;
          10'b0000000_111: op = rvfi_pkg::OP_AND;
          10'b0000000_110: op = rvfi_pkg::OP_OR;
          10'b0000000_100: op = rvfi_pkg::OP_XOR;
          default:         op = rvfi_pkg::OP_ILLEGAL;
        endcase
      end
      7'b0110111: op = rvfi_pkg::OP_LUI;
      7'b0000011: begin
        if (funct3 == 3'b010) op = rvfi_pkg::OP_LW;
      end
      7'b0100011: begin
        if (funct3 == 3'b010) op = rvfi_pkg::OP_SW;
      end
      7'b1100011: begin
        if (funct3 == 3'b000) op = rvfi_pkg::OP_BEQ;
        if (funct3 == 3'b001) op = rvfi_pkg::OP_BNE;
      end
      7'b1101111: op = rvfi_pkg::OP_JAL;
      default:    op = rvfi_pkg::OP_ILLEGAL;
    endcase
  end

  // ==================================================
  // Immediates
  // ==================================================
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // ==================================================
  // Result and write-back
  // ==================================================
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (op)
      rvfi_pkg::OP_ADDI: rd_wdata = rs1_rdata + imm_i;
      rvfi_pkg::OP_ADD:  rd_wdata = rs1_rdata + rs2_rdata;
      rvfi_pkg::OP_SUB:  rd_wdata = rs1_rdata - rs2_rdata;
      rvfi_pkg::OP_AND:  rd_wdata = rs1_rdata & rs2_rdata;
      rvfi_pkg::OP_OR:   rd_wdata = rs1_rdata | rs2_rdata;
      rvfi_pkg::OP_XOR:  rd_wdata = rs1_rdata ^ rs2_rdata;
      rvfi_pkg::OP_LUI:  rd_wdata = imm_u;
      rvfi_pkg::OP_LW:   rd_wdata = load_data;
      // Link address
      rvfi_pkg::OP_JAL:  rd_wdata = pc_plus4;
      default:           rd_wdata = 32'h0;
    endcase
  end

  // No write for stores, branches and illegal ops
  assign rd_write = !((op == rvfi_pkg::OP_SW) || (op == rvfi_pkg::OP_BEQ) ||
                      (op == rvfi_pkg::OP_BNE) || (op == rvfi_pkg::OP_ILLEGAL));
  assign rd_addr  = rd_write ? insn[11:7] : 5'd0;

  // ==================================================
  // Memory address and data
  // ==================================================
  assign mem_addr   = rs1_rdata + ((op == rvfi_pkg::OP_SW) ? imm_s : imm_i);
  assign store_data = rs2_rdata;

  // ==================================================
  // Next PC
  // ==================================================
  assign taken = ((op == rvfi_pkg::OP_BEQ) && (rs1_rdata == rs2_rdata)) ||
                 ((op == rvfi_pkg::OP_BNE) && (rs1_rdata != rs2_rdata));

  always_comb begin
    if (op == rvfi_pkg::OP_ILLEGAL) begin
      // Trap leaves the PC where it is
      next_pc = pc;
    end else if (op == rvfi_pkg::OP_JAL) begin
      next_pc = pc + imm_j;
    end else if (taken) begin
      next_pc = pc + imm_b;
    end else begin
      next_pc = pc_plus4;
    end
  end

endmodule

//--- logic/regfile.sv
/*
 * Integer register file
 * 32 x 32-bit, two combinational reads, one synchronous write
 * x0 reads as zero
 */

`timescale 1ns/1ps

module regfile (
  input  logic        clock,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_wdata,
  input  logic        write_en,
  output logic [31:0] rs1_rdata,
  output logic [31:0] rs2_rdata
);

  // Entry 0 is never written
  logic [31:0] regs [32];

  // Write port, x0 dropped
  always_ff @(posedge clock) begin
    if (write_en && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_wdata;
    end
  end

  // Read ports
  assign rs1_rdata = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
  assign rs2_rdata = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

//--- logic/core_sequencer.sv
/*
 * Core sequencer
 * Steps each instruction through fetch, execute, memory and retire
 * Memory step only for loads and stores, halts after an illegal op
 */

`timescale 1ns/1ps

module core_sequencer (
  input  logic           clock,
  input  logic           reset,
  input  logic           run,
  input  rvfi_pkg::op_e  op,
  output logic           fetch_en,
  output logic           mem_en,
  output logic           retire_en,
  output logic           halted
);

  rvfi_pkg::seq_state_e state;
  rvfi_pkg::seq_state_e state_next;

  // Loads and stores need the extra memory step
  logic is_mem_op;

  assign is_mem_op = (op == rvfi_pkg::OP_LW) || (op == rvfi_pkg::OP_SW);

  // ==================================================
  // State register
  // ==================================================
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rvfi_pkg::FETCH;
    end else begin
      state <= state_next;
    end
  end

  // ==================================================
  // Next state
  // ==================================================
  always_comb begin
    state_next = state;
    // Every step waits on run
    if (run) begin
      case (state)
        rvfi_pkg::FETCH: begin
          state_next = rvfi_pkg::EXECUTE;
        end
        rvfi_pkg::EXECUTE: begin
          // Insn is valid here, op already decoded
          state_next = is_mem_op ? rvfi_pkg::MEMORY : rvfi_pkg::RETIRE;
        end
        rvfi_pkg::MEMORY: begin
          state_next = rvfi_pkg::RETIRE;
        end
        rvfi_pkg::RETIRE: begin
          if (op == rvfi_pkg::OP_ILLEGAL) begin
            state_next = rvfi_pkg::HALTED;
          end else begin
            state_next = rvfi_pkg::FETCH;
          end
        end
        rvfi_pkg::HALTED: begin
          // Sticky until reset
          state_next = rvfi_pkg::HALTED;
        end
        default: begin
          state_next = rvfi_pkg::FETCH;
        end
      endcase
    end
  end

  // ==================================================
  // Step enables
  // ==================================================
  assign fetch_en  = run && (state == rvfi_pkg::FETCH);
  assign mem_en    = run && (state == rvfi_pkg::MEMORY);
  assign retire_en = run && (state == rvfi_pkg::RETIRE);
  assign halted    = (state == rvfi_pkg::HALTED);

endmodule

//--- logic/rvfi_pkg.sv
/*
 * Shared types for the RVFI demo core
 * Sequencer states and decoded operations
 */

package rvfi_pkg;

  // ==================================================
  // Sequencer states
  // ==================================================
  typedef enum logic [2:0] {
    FETCH   = 3'd0,
    EXECUTE = 3'd1,
    MEMORY  = 3'd2,
    RETIRE  = 3'd3,
    HALTED  = 3'd4
  } seq_state_e;

  // ==================================================
  // Decoded operations
  // ==================================================
  typedef enum logic [3:0] {
    OP_ADDI    = 4'd0,
    OP_ADD     = 4'd1,
    OP_SUB     = 4'd2,
    OP_AND     = 4'd3,
    OP_OR      = 4'd4,
    OP_XOR     = 4'd5,
    OP_LUI     = 4'd6,
    OP_LW      = 4'd7,
    OP_SW      = 4'd8,
    OP_BEQ     = 4'd9,
    OP_BNE     = 4'd10,
    OP_JAL     = 4'd11,
    // Anything outside the subset
    OP_ILLEGAL = 4'd15
  } op_e;

endpackage

//--- logic/rvfi_params.svh
/*
 * Core parameters for the RVFI demo core
 * Reset vector and unified memory geometry
 */

`ifndef RVFI_PARAMS_SVH
`define RVFI_PARAMS_SVH

// ==================================================
// Program counter
// ==================================================
// First fetch address after reset
`define RVFI_RESET_PC 32'h0000_0000

// ==================================================
// Unified memory
// ==================================================
// Depth in 32-bit words
`define RVFI_MEM_WORDS 4096
// Word address width, log2 of the depth
`define RVFI_MEM_AW 12

`endif
